/* Makefile */
VERILATOR ?= verilator
TOP ?= tb_memory_island
LOG ?= sim.log
BUILD_DIR ?= build

BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) --binary -f list.f --top-module $(TOP) -Mdir $(BUILD_DIR) -o V$(TOP)

run: compile
	./$(BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ]; then exit 1; fi; \
	if grep -q "TB FAILED" $(LOG); then exit 1; fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* list.f */
verilog/memory_island_pkg.sv
verilog/mem_port_if.sv
verilog/tcdm_xbar.sv
verilog/wide_narrow_arbiter.sv
verilog/sram_bank.sv
verilog/memory_island_core.sv
tests/tb_memory_island.sv

/* tests/tb_memory_island.sv */
`timescale 1ns/1ps

module tb_memory_island import memory_island_pkg::*; ();

    localparam int HalfPeriod = 20;
    localparam int InputDelay = 2;
    localparam int ResetCycles = 10;
    localparam int RrOps = 6;
    localparam int RandOps = 30;
    // Directed ops, then three random streams
    localparam int TotalOps = 52 + 3 * RandOps;
    localparam int TimeoutCycles = TotalOps * 8 + 200;

    logic clk = 1'b0;
    logic reset_i;
    logic [NumNarrowReq-1:0] narrow_req;
    logic [NumNarrowReq-1:0][AddrWidth-1:0] narrow_addr;
    logic [NumNarrowReq-1:0] narrow_we;
    logic [NumNarrowReq-1:0][NarrowDataWidth-1:0] narrow_wdata;
    logic [NumNarrowReq-1:0][NarrowBeWidth-1:0] narrow_be;
    logic [NumNarrowReq-1:0] narrow_gnt;
    logic [NumNarrowReq-1:0] narrow_rvalid;
    logic [NumNarrowReq-1:0][NarrowDataWidth-1:0] narrow_rdata;
    logic wide_req;
    logic [AddrWidth-1:0] wide_addr;
    logic wide_we;
    logic [WideDataWidth-1:0] wide_wdata;
    logic [WideBeWidth-1:0] wide_be;
    logic wide_gnt;
    logic wide_rvalid;
    logic [WideDataWidth-1:0] wide_rdata;

    // Byte model of the island, with written-byte flags
    logic [7:0] model_mem [1 << AddrWidth];
    logic model_ok [1 << AddrWidth];
    // Responses expected in the next cycle
    logic [NumNarrowReq-1:0] exp_nvalid;
    logic [63:0] exp_ndata [NumNarrowReq];
    logic [63:0] exp_nmask [NumNarrowReq];
    logic exp_wvalid;
    logic [63:0] exp_wdata;
    logic [63:0] exp_wmask;
    int error_count = 0;
    int seed = 32'h5a55_900d;

    memory_island_core memory_island_core_inst (
        .clk_i(clk), .reset_i(reset_i),
        .narrow_req_i(narrow_req), .narrow_addr_i(narrow_addr), .narrow_we_i(narrow_we),
        .narrow_wdata_i(narrow_wdata), .narrow_be_i(narrow_be), .narrow_gnt_o(narrow_gnt),
        .narrow_rvalid_o(narrow_rvalid), .narrow_rdata_o(narrow_rdata),
        .wide_req_i(wide_req), .wide_addr_i(wide_addr), .wide_we_i(wide_we),
        .wide_wdata_i(wide_wdata), .wide_be_i(wide_be), .wide_gnt_o(wide_gnt),
        .wide_rvalid_o(wide_rvalid), .wide_rdata_o(wide_rdata)
    );

    always #(HalfPeriod) clk = ~clk;

    task automatic check_equal(input logic [63:0] actual, input logic [63:0] expected,
                               input string what);
        if (actual !== expected) begin
            error_count++;
            $display("** Error at %0t: %s, got %h expected %h", $time, what, actual, expected);
        end
    endtask

    // --------------------
    // Reference model
    // --------------------
    task automatic model_write(input logic [AddrWidth-1:0] base, input int nbytes,
                               input logic [63:0] data, input logic [7:0] be);
        logic [AddrWidth-1:0] a;
        for (int i = 0; i < nbytes; i++) begin
            a = base + AddrWidth'(i);
            if (be[i]) begin
                model_mem[a] = data[i*8 +: 8];
                model_ok[a] = 1'b1;
            end
        end
    endtask

    // Unwritten bytes drop out of the mask
    task automatic model_read(input logic [AddrWidth-1:0] base, input int nbytes,
                              output logic [63:0] data, output logic [63:0] mask);
        logic [AddrWidth-1:0] a;
        data = '0;
        mask = '0;
        for (int i = 0; i < nbytes; i++) begin
            a = base + AddrWidth'(i);
            data[i*8 +: 8] = model_mem[a];
            mask[i*8 +: 8] = model_ok[a] ? 8'hff : 8'h00;
        end
    endtask

    // Response checks, then grants of this cycle into the model
    always @(negedge clk) begin
        if (reset_i) begin
            exp_nvalid = '0;
            exp_wvalid = 1'b0;
        end else begin
            for (int p = 0; p < NumNarrowReq; p++) begin
                check_equal(64'(narrow_rvalid[p]), 64'(exp_nvalid[p]),
                            $sformatf("narrow port %0d rvalid timing", p));
                if (exp_nvalid[p] && narrow_rvalid[p])
                    check_equal(64'(narrow_rdata[p]) & exp_nmask[p], exp_ndata[p] & exp_nmask[p],
                                $sformatf("narrow port %0d rdata", p));
            end
            check_equal(64'(wide_rvalid), 64'(exp_wvalid), "wide rvalid timing");
            if (exp_wvalid && wide_rvalid)
                check_equal(wide_rdata & exp_wmask, exp_wdata & exp_wmask, "wide rdata");
            exp_nvalid = narrow_gnt;
            for (int p = 0; p < NumNarrowReq; p++) begin
                exp_nmask[p] = '0;
                if (narrow_gnt[p] && narrow_we[p])
                    model_write(narrow_addr[p] & 10'h3fc, 4, 64'(narrow_wdata[p]), 8'(narrow_be[p]));
                else if (narrow_gnt[p])
                    model_read(narrow_addr[p] & 10'h3fc, 4, exp_ndata[p], exp_nmask[p]);
            end
            exp_wvalid = wide_gnt;
            exp_wmask = '0;
            if (wide_gnt && wide_we)
                model_write(wide_addr & 10'h3f8, 8, wide_wdata, wide_be);
            else if (wide_gnt)
                model_read(wide_addr & 10'h3f8, 8, exp_wdata, exp_wmask);
        end
    end

    // --------------------
    // Drivers
    // --------------------
    task automatic reset_dut();
        reset_i = 1'b1;
        repeat (ResetCycles) @(posedge clk);
        #(InputDelay);
        reset_i = 1'b0;
    endtask

    // Hold the request until granted, return just after the granted edge
    task automatic narrow_op(input int p, input logic [AddrWidth-1:0] addr, input logic we,
                             input logic [31:0] data, input logic [3:0] be);
        narrow_addr[p] = addr;
        narrow_we[p] = we;
        narrow_wdata[p] = data;
        narrow_be[p] = be;
        narrow_req[p] = 1'b1;
        @(negedge clk);
        while (!narrow_gnt[p]) @(negedge clk);
        @(posedge clk);
        #(InputDelay);
        narrow_req[p] = 1'b0;
    endtask

    task automatic wide_op(input logic [AddrWidth-1:0] addr, input logic we,
                           input logic [63:0] data, input logic [7:0] be);
        wide_addr = addr;
        wide_we = we;
        wide_wdata = data;
        wide_be = be;
        wide_req = 1'b1;
        @(negedge clk);
        while (!wide_gnt) @(negedge clk);
        @(posedge clk);
        #(InputDelay);
        wide_req = 1'b0;
    endtask

    // --------------------
    // Directed tests
    // --------------------
    task automatic test_reset_and_narrow();
        logic [AddrWidth-1:0] addr;
        @(negedge clk);
        check_equal(64'(narrow_gnt), 64'd0, "narrow gnt after reset");
        check_equal(64'(narrow_rvalid), 64'd0, "narrow rvalid after reset");
        check_equal(64'(wide_gnt), 64'd0, "wide gnt after reset");
        check_equal(64'(wide_rvalid), 64'd0, "wide rvalid after reset");
        @(posedge clk);
        #(InputDelay);
        for (int p = 0; p < NumNarrowReq; p++) begin
            for (int b = 0; b < NumNarrowBanks; b++) begin
                addr = {6'(1 + p), 2'(b), 2'b00};
                narrow_op(p, addr, 1'b1, 32'hc0de_0000 | 32'(p * 16 + b), 4'hf);
                // Partial write over the full word
                narrow_op(p, addr, 1'b1, 32'h5a5a_a5a5, (b % 2 == 0) ? 4'b0101 : 4'b1010);
                narrow_op(p, addr, 1'b0, 32'h0, 4'hf);
            end
        end
    endtask

    task automatic test_wide_write_narrow_read();
        wide_op(10'h050, 1'b1, 64'h0123_4567_89ab_cdef, 8'hff);
        wide_op(10'h058, 1'b1, 64'hfedc_ba98_7654_3210, 8'hff);
        for (int b = 0; b < NumNarrowBanks; b++)
            narrow_op(b % 2, {6'd5, 2'(b), 2'b00}, 1'b0, 32'h0, 4'hf);
    endtask

    task automatic test_narrow_write_wide_read();
        for (int b = 0; b < NumNarrowBanks; b++)
            narrow_op(0, {6'd7, 2'(b), 2'b00}, 1'b1, 32'hbeef_0000 | 32'(b), 4'hf);
        wide_op(10'h070, 1'b0, 64'h0, 8'hff);
        wide_op(10'h078, 1'b0, 64'h0, 8'hff);
    endtask

    task automatic test_round_robin();
        // Last response of the previous test lands before the reset
        @(posedge clk);
        #(InputDelay);
        // Pointers back at port 0
        reset_dut();
        fork
            for (int i = 0; i < RrOps; i++)
                narrow_op(0, {6'(10 + i % 3), 2'd2, 2'b00}, i < 3, 32'h1000_0000 | 32'(i), 4'hf);
            for (int i = 0; i < RrOps; i++)
                narrow_op(1, {6'(20 + i % 3), 2'd2, 2'b00}, i < 3, 32'h2000_0000 | 32'(i), 4'hf);
            begin : watch_grants
                int seen;
                seen = 0;
                while (seen < 2 * RrOps) begin
                    @(negedge clk);
                    if (narrow_gnt != '0) begin
                        check_equal(64'(narrow_gnt), (seen % 2 == 0) ? 64'd1 : 64'd2,
                                    "round-robin grant order");
                        seen++;
                    end
                end
            end
        join
    endtask

    task automatic test_narrow_priority();
        narrow_addr[0] = 10'h070;
        narrow_we[0] = 1'b0;
        narrow_req[0] = 1'b1;
        wide_addr = 10'h070;
        wide_we = 1'b0;
        wide_req = 1'b1;
        @(negedge clk);
        check_equal(64'(narrow_gnt[0]), 64'd1, "narrow granted over wide");
        check_equal(64'(wide_gnt), 64'd0, "wide held off by narrow");
        @(posedge clk);
        #(InputDelay);
        narrow_req[0] = 1'b0;
        @(negedge clk);
        check_equal(64'(wide_gnt), 64'd1, "wide granted on free pair");
        @(posedge clk);
        #(InputDelay);
        // Wide to the other pair goes alongside narrow
        narrow_req[0] = 1'b1;
        wide_addr = 10'h078;
        @(negedge clk);
        check_equal(64'(narrow_gnt[0]), 64'd1, "narrow granted with wide on other pair");
        check_equal(64'(wide_gnt), 64'd1, "wide granted on other pair");
        @(posedge clk);
        #(InputDelay);
        narrow_req[0] = 1'b0;
        wide_req = 1'b0;
    endtask

    task automatic random_narrow(input int p);
        logic [31:0] r;
        logic [3:0] be;
        for (int i = 0; i < RandOps; i++) begin
            r = $random(seed);
            be = (r[14:11] == 4'h0) ? 4'hf : r[14:11];
            narrow_op(p, r[9:0] & 10'h3fc, r[10], $random(seed), be);
        end
    endtask

    task automatic random_wide();
        logic [31:0] r;
        logic [7:0] be;
        for (int i = 0; i < RandOps; i++) begin
            r = $random(seed);
            be = (r[18:11] == 8'h00) ? 8'hff : r[18:11];
            wide_op(r[9:0] & 10'h3f8, r[10], {$random(seed), $random(seed)}, be);
        end
    endtask

    task automatic test_random_mixed();
        fork
            random_narrow(0);
            random_narrow(1);
            random_wide();
        join
    endtask

    // --------------------
    // Main sequence and watchdog
    // --------------------
    initial begin
        reset_i = 1'b1;
        narrow_req = '0;
        narrow_addr = '0;
        narrow_we = '0;
        narrow_wdata = '0;
        narrow_be = '0;
        wide_req = 1'b0;
        wide_addr = '0;
        wide_we = 1'b0;
        wide_wdata = '0;
        wide_be = '0;
        for (int i = 0; i < (1 << AddrWidth); i++)
            model_ok[i] = 1'b0;
        reset_dut();
        test_reset_and_narrow();
        test_wide_write_narrow_read();
        test_narrow_write_wide_read();
        test_round_robin();
        test_narrow_priority();
        test_random_mixed();
        // Let the last responses drain
        repeat (3) @(posedge clk);
        $display("Errors: %0d", error_count);
        if (error_count == 0)
            $display("TB PASSED");
        else
            $display("TB FAILED");
        $finish;
    end

    initial begin
        repeat (TimeoutCycles) @(posedge clk);
        $display("Simulation timed out after %0d cycles waiting for a grant", TimeoutCycles);
        $display("TB FAILED");
        $finish;
    end

endmodule

/* verilog/mem_port_if.sv */
`timescale 1ns/1ps

// Bank-side request/grant/response bundle
interface mem_port_if
    import memory_island_pkg::*;
#(
    parameter int unsigned DataWidth = 32
);

    // Request side, held stable until gnt
    logic req;
    logic gnt;
    word_addr_t addr;
    logic we;
    logic [DataWidth-1:0] wdata;
    logic [DataWidth/8-1:0] be;

    // Response side, one cycle after the grant
    logic rvalid;
    logic [DataWidth-1:0] rdata;

    // Requestor view
    modport initiator (
        output req,
        output addr,
        output we,
        output wdata,
        output be,
        input gnt,
        input rvalid,
        input rdata
    );

    // Responder view
    modport target (
        input req,
        input addr,
        input we,
        input wdata,
        input be,
        output gnt,
        output rvalid,
        output rdata
    );

endinterface

/* verilog/memory_island_core.sv */
`timescale 1ns/1ps

module memory_island_core import memory_island_pkg::*; (
    input logic clk_i,
    input logic reset_i,

    // Narrow requestors
    input logic [NumNarrowReq-1:0] narrow_req_i,
    input logic [NumNarrowReq-1:0][AddrWidth-1:0] narrow_addr_i,
    input logic [NumNarrowReq-1:0] narrow_we_i,
    input logic [NumNarrowReq-1:0][NarrowDataWidth-1:0] narrow_wdata_i,
    input logic [NumNarrowReq-1:0][NarrowBeWidth-1:0] narrow_be_i,
    output logic [NumNarrowReq-1:0] narrow_gnt_o,
    output logic [NumNarrowReq-1:0] narrow_rvalid_o,
    output logic [NumNarrowReq-1:0][NarrowDataWidth-1:0] narrow_rdata_o,

    // Wide requestor
    input logic wide_req_i,
    input logic [AddrWidth-1:0] wide_addr_i,
    input logic wide_we_i,
    input logic [WideDataWidth-1:0] wide_wdata_i,
    input logic [WideBeWidth-1:0] wide_be_i,
    output logic wide_gnt_o,
    output logic wide_rvalid_o,
    output logic [WideDataWidth-1:0] wide_rdata_o
);

    // --------------------
    // Internal bundles
    // --------------------

    // Crossbar to arbiter, one per bank
    mem_port_if #(.DataWidth(NarrowDataWidth)) narrow_bank [NumNarrowBanks] ();
    // Arbiter to SRAM, one per bank
    mem_port_if #(.DataWidth(NarrowDataWidth)) bank [NumNarrowBanks] ();

    // --------------------
    // Narrow crossbar
    // --------------------
    tcdm_xbar #(
        .NumReq(NumNarrowReq)
    ) tcdm_xbar_inst (
        .clk_i(clk_i),
        .reset_i(reset_i),
        .req_i(narrow_req_i),
        .addr_i(narrow_addr_i),
        .we_i(narrow_we_i),
        .wdata_i(narrow_wdata_i),
        .be_i(narrow_be_i),
        .gnt_o(narrow_gnt_o),
        .rvalid_o(narrow_rvalid_o),
        .rdata_o(narrow_rdata_o),
        .bank_o(narrow_bank)
    );

    // --------------------
    // Narrow/wide arbitration
    // --------------------

    // Wide port has a single requestor, decoded inside
    wide_narrow_arbiter wide_narrow_arbiter_inst (
        .clk_i(clk_i),
        .reset_i(reset_i),
        .narrow_i(narrow_bank),
        .wide_req_i(wide_req_i),
        .wide_addr_i(wide_addr_i),
        .wide_we_i(wide_we_i),
        .wide_wdata_i(wide_wdata_i),
        .wide_be_i(wide_be_i),
        .wide_gnt_o(wide_gnt_o),
        .wide_rvalid_o(wide_rvalid_o),
        .wide_rdata_o(wide_rdata_o),
        .bank_o(bank)
    );

    // --------------------
    // Banks
    // --------------------
    for (genvar b = 0; b < NumNarrowBanks; b++) begin : gen_sram
        sram_bank #(
            .NumWords(WordsPerBank),
            .DataWidth(NarrowDataWidth)
        ) sram_bank_inst (
            .clk_i(clk_i),
            .port_i(bank[b])
        );
    end

endmodule

/* verilog/memory_island_pkg.sv */
package memory_island_pkg;

    // --------------------
    // Island geometry
    // --------------------

    // Byte address into the 1 KiB island
    localparam int unsigned AddrWidth = 10;

    // Requestor word widths
    localparam int unsigned NarrowDataWidth = 32;
    localparam int unsigned WideDataWidth = 64;
    localparam int unsigned NarrowBeWidth = NarrowDataWidth / 8;
    localparam int unsigned WideBeWidth = WideDataWidth / 8;

    // Banking
    localparam int unsigned NumNarrowBanks = 4;
    localparam int unsigned WordsPerBank = 64;
    localparam int unsigned NumNarrowReq = 2;
    localparam int unsigned NumNarrowBanksInWide = WideDataWidth / NarrowDataWidth;
    localparam int unsigned NumWideBanks = NumNarrowBanks / NumNarrowBanksInWide;

    // --------------------
    // Address fields
    // --------------------

    // Narrow bank select starts above the byte offset
    localparam int unsigned AddrBankWordBit = $clog2(NarrowDataWidth / 8);
    // Wide pair select starts above the wide byte offset
    localparam int unsigned AddrWideWordBit = $clog2(WideDataWidth / 8);
    localparam int unsigned NarrowBankSelWidth = $clog2(NumNarrowBanks);
    // In-bank word sits above the narrow bank select
    localparam int unsigned AddrInBankBit = AddrBankWordBit + NarrowBankSelWidth;
    localparam int unsigned InBankAddrWidth = $clog2(WordsPerBank);

    // Narrow bank index
    typedef logic [NarrowBankSelWidth-1:0] bank_sel_t;
    // Word index inside one bank
    typedef logic [InBankAddrWidth-1:0] word_addr_t;

endpackage

/* verilog/sram_bank.sv */
`timescale 1ns/1ps

module sram_bank #(
    parameter int unsigned NumWords = 64,
    parameter int unsigned DataWidth = 32
) (
    input logic clk_i,

    mem_port_if.target port_i
);

    localparam int unsigned BeWidth = DataWidth / 8;

    // Storage and read register
    logic [DataWidth-1:0] mem_q [NumWords];
    logic [DataWidth-1:0] rdata_q;
    logic rvalid_q;

    // Bank is always ready
    assign port_i.gnt = 1'b1;

    // Byte-masked write, registered read
    always_ff @(posedge clk_i) begin
        if (port_i.req) begin
            if (port_i.we) begin
                for (int i = 0; i < BeWidth; i++) begin
                    if (port_i.be[i]) begin
                        mem_q[port_i.addr][i*8 +: 8] <= port_i.wdata[i*8 +: 8];
                    end
                end
            end else begin
                rdata_q <= mem_q[port_i.addr];
            end
        end
    end

    // One response per accepted request, writes included
    always_ff @(posedge clk_i) begin
        rvalid_q <= port_i.req;
    end

    assign port_i.rvalid = rvalid_q;
    assign port_i.rdata = rdata_q;

endmodule

/* verilog/tcdm_xbar.sv */
`timescale 1ns/1ps

module tcdm_xbar import memory_island_pkg::*; #(
    parameter int unsigned NumReq = 2
) (
    input logic clk_i,
    input logic reset_i,

    input logic [NumReq-1:0] req_i,
    input logic [NumReq-1:0][AddrWidth-1:0] addr_i,
    input logic [NumReq-1:0] we_i,
    input logic [NumReq-1:0][NarrowDataWidth-1:0] wdata_i,
    input logic [NumReq-1:0][NarrowBeWidth-1:0] be_i,
    output logic [NumReq-1:0] gnt_o,
    output logic [NumReq-1:0] rvalid_o,
    output logic [NumReq-1:0][NarrowDataWidth-1:0] rdata_o,

    mem_port_if.initiator bank_o [NumNarrowBanks]
);

    // Port index width, kept at least one bit
    localparam int unsigned PortIdxWidth = (NumReq > 1) ? $clog2(NumReq) : 1;

    // Per-port address decode
    bank_sel_t [NumReq-1:0] port_bank;
    word_addr_t [NumReq-1:0] port_word;

    // Per-bank arbitration state
    logic [NumNarrowBanks-1:0] win_valid;
    logic [NumNarrowBanks-1:0][PortIdxWidth-1:0] win_idx;
    logic [NumNarrowBanks-1:0][PortIdxWidth-1:0] rr_q;
    logic [NumNarrowBanks-1:0][PortIdxWidth-1:0] resp_idx_q;

    // Bank-side feedback, flattened out of the interface array
    logic [NumNarrowBanks-1:0] bank_gnt;
    logic [NumNarrowBanks-1:0] bank_rvalid;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0] bank_rdata;

    // --------------------
    // Decode
    // --------------------
    for (genvar p = 0; p < NumReq; p++) begin : gen_decode
        assign port_bank[p] = addr_i[p][AddrBankWordBit +: NarrowBankSelWidth];
        assign port_word[p] = addr_i[p][AddrInBankBit +: InBankAddrWidth];
    end

    // --------------------
    // Round-robin per bank
    // --------------------
    always_comb begin
        int unsigned idx;
        win_valid = '0;
        win_idx = '0;
        for (int b = 0; b < NumNarrowBanks; b++) begin
            // Search starts at the pointer, first hit wins
            for (int i = 0; i < NumReq; i++) begin
                idx = (int'(rr_q[b]) + i) % NumReq;
                if (!win_valid[b] && req_i[idx] && port_bank[idx] == bank_sel_t'(b)) begin
                    win_valid[b] = 1'b1;
                    win_idx[b] = PortIdxWidth'(idx);
                end
            end
        end
    end

    // Winner drives its bank
    for (genvar b = 0; b < NumNarrowBanks; b++) begin : gen_bank
        assign bank_o[b].req = win_valid[b];
        assign bank_o[b].addr = port_word[win_idx[b]];
        assign bank_o[b].we = we_i[win_idx[b]];
        assign bank_o[b].wdata = wdata_i[win_idx[b]];
        assign bank_o[b].be = be_i[win_idx[b]];
        assign bank_gnt[b] = bank_o[b].gnt;
        assign bank_rvalid[b] = bank_o[b].rvalid;
        assign bank_rdata[b] = bank_o[b].rdata;
    end

    // Pointer moves past the granted port, granted port kept for the response
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            rr_q <= '0;
            resp_idx_q <= '0;
        end else begin
            for (int b = 0; b < NumNarrowBanks; b++) begin
                if (win_valid[b] && bank_gnt[b]) begin
                    rr_q[b] <= (int'(win_idx[b]) == NumReq - 1) ? '0 : win_idx[b] + 1'b1;
                    resp_idx_q[b] <= win_idx[b];
                end
            end
        end
    end

    // --------------------
    // Grant and response routing
    // --------------------
    always_comb begin
        gnt_o = '0;
        rvalid_o = '0;
        rdata_o = '0;
        for (int b = 0; b < NumNarrowBanks; b++) begin
            if (win_valid[b] && bank_gnt[b]) begin
                gnt_o[win_idx[b]] = 1'b1;
            end
            // At most one bank answers a given port
            if (bank_rvalid[b]) begin
                rvalid_o[resp_idx_q[b]] = 1'b1;
                rdata_o[resp_idx_q[b]] = bank_rdata[b];
            end
        end
    end

endmodule

/* verilog/wide_narrow_arbiter.sv */
`timescale 1ns/1ps

module wide_narrow_arbiter import memory_island_pkg::*; (
    input logic clk_i,
    input logic reset_i,

    mem_port_if.target narrow_i [NumNarrowBanks],

    input logic wide_req_i,
    input logic [AddrWidth-1:0] wide_addr_i,
    input logic wide_we_i,
    input logic [WideDataWidth-1:0] wide_wdata_i,
    input logic [WideBeWidth-1:0] wide_be_i,
    output logic wide_gnt_o,
    output logic wide_rvalid_o,
    output logic [WideDataWidth-1:0] wide_rdata_o,

    mem_port_if.initiator bank_o [NumNarrowBanks]
);

    localparam int unsigned WideSelWidth = (NumWideBanks > 1) ? $clog2(NumWideBanks) : 1;

    // Wide address decode
    logic [WideSelWidth-1:0] wide_sel;
    word_addr_t wide_word;

    // Bank occupancy
    logic [NumNarrowBanks-1:0] narrow_req;
    logic [NumNarrowBanks-1:0] wide_mask;
    logic [NumNarrowBanks-1:0] wide_take;
    logic wide_blocked;
    logic wide_go;
    logic wide_done;

    // Flattened bank feedback
    logic [NumNarrowBanks-1:0] bank_gnt;
    logic [NumNarrowBanks-1:0] bank_rvalid;
    logic [NumNarrowBanks-1:0][NarrowDataWidth-1:0] bank_rdata;

    // Who owned each bank last cycle
    logic [NumNarrowBanks-1:0] narrow_served_q;
    logic wide_served_q;
    logic [WideSelWidth-1:0] wide_sel_q;

    assign wide_sel = wide_addr_i[AddrWideWordBit +: WideSelWidth];
    assign wide_word = wide_addr_i[AddrInBankBit +: InBankAddrWidth];

    // --------------------
    // Selection
    // --------------------
    always_comb begin
        for (int b = 0; b < NumNarrowBanks; b++) begin
            wide_mask[b] = (b / NumNarrowBanksInWide) == int'(wide_sel);
        end
    end

    // Narrow first, wide only on a fully idle pair
    assign wide_blocked = |(narrow_req & wide_mask);
    assign wide_go = wide_req_i & ~wide_blocked;
    assign wide_take = wide_go ? wide_mask : '0;
    assign wide_gnt_o = wide_go & (&(bank_gnt | ~wide_mask));

    for (genvar b = 0; b < NumNarrowBanks; b++) begin : gen_bank
        // Lower bank of the pair gets the low half
        localparam int unsigned Half = b % NumNarrowBanksInWide;

        assign narrow_req[b] = narrow_i[b].req;
        assign bank_gnt[b] = bank_o[b].gnt;
        assign bank_rvalid[b] = bank_o[b].rvalid;
        assign bank_rdata[b] = bank_o[b].rdata;

        assign bank_o[b].req = narrow_req[b] | wide_take[b];
        assign bank_o[b].addr = narrow_req[b] ? narrow_i[b].addr : wide_word;
        assign bank_o[b].we = narrow_req[b] ? narrow_i[b].we : wide_we_i;
        assign bank_o[b].wdata = narrow_req[b] ? narrow_i[b].wdata
                                               : wide_wdata_i[Half*NarrowDataWidth +: NarrowDataWidth];
        assign bank_o[b].be = narrow_req[b] ? narrow_i[b].be
                                            : wide_be_i[Half*NarrowBeWidth +: NarrowBeWidth];

        // Narrow side is never stalled here
        assign narrow_i[b].gnt = narrow_req[b] & bank_gnt[b];
        assign narrow_i[b].rvalid = bank_rvalid[b] & narrow_served_q[b];
        assign narrow_i[b].rdata = bank_rdata[b];
    end

    // --------------------
    // Ownership tracking
    // --------------------
    always_ff @(posedge clk_i) begin
        if (reset_i) begin
            narrow_served_q <= '0;
            wide_served_q <= 1'b0;
            wide_sel_q <= '0;
        end else begin
            narrow_served_q <= narrow_req & bank_gnt;
            wide_served_q <= wide_gnt_o;
            if (wide_gnt_o) begin
                wide_sel_q <= wide_sel;
            end
        end
    end

    // Wide response, halves joined in bank order
    always_comb begin
        wide_rdata_o = '0;
        wide_done = 1'b1;
        for (int h = 0; h < NumNarrowBanksInWide; h++) begin
            wide_rdata_o[h*NarrowDataWidth +: NarrowDataWidth] =
                bank_rdata[int'(wide_sel_q)*NumNarrowBanksInWide + h];
            wide_done &= bank_rvalid[int'(wide_sel_q)*NumNarrowBanksInWide + h];
        end
    end

    assign wide_rvalid_o = wide_served_q & wide_done;

endmodule
